/* logic/lcd_pkg.sv */
`default_nettype none

package lcd_pkg;

    // rom layout
    localparam int rom_depth  = 24;
    localparam int rom_addr_w = 5;
    localparam int rom_word_w = 18;
    localparam int init_end   = 9;   // last script word, logo follows
    localparam int wait_bit   = 17;
    localparam int rs_bit     = 16;

    // screen and delays, shrunk for simulation
    localparam int          frame_pixels = 16;
    localparam logic [15:0] fill_color   = 16'hffff;
    localparam int          delay_cycles = 40;
    localparam int          keep_cycles  = 64;
    localparam int          dly_w        = $clog2(keep_cycles);  // keep_cycles is the longer one
    localparam int          pix_w        = $clog2(frame_pixels);

    // write strobe phases
    localparam int wr_low_cycles  = 2;
    localparam int wr_high_cycles = 2;
    localparam int phase_w        = $clog2(wr_low_cycles + wr_high_cycles);

    // axi4-lite register map
    localparam int                     axil_addr_w = 4;
    localparam int                     axil_data_w = 32;
    localparam logic [axil_addr_w-1:0] reg_status  = 4'h0;
    localparam logic [axil_addr_w-1:0] reg_cmd     = 4'h4;
    localparam logic [axil_addr_w-1:0] reg_data    = 4'h8;
    localparam logic [axil_addr_w-1:0] reg_ctrl    = 4'hc;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef enum logic [2:0] {
        idle,
        script,
        script_wait,
        fill,
        logo,
        keep,
        done
    } init_state_e;

    typedef enum logic [1:0] {
        w_idle,
        w_issue,
        w_resp
    } axil_wstate_e;

endpackage

`default_nettype wire

/* logic/lcd_init_rom.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_init_rom import lcd_pkg::*; (
    input  logic                  pclk,
    input  logic [rom_addr_w-1:0] rom_addr,
    output logic [rom_word_w-1:0] rom_word
);

    // {wait, rs, data}
    function automatic logic [rom_word_w-1:0] rom_lookup(input logic [rom_addr_w-1:0] a);
        logic [15:0] logo_val;
        logo_val = 16'hf800 + 16'(a - rom_addr_w'(init_end + 1)) * 16'h0101;
        case (a)
            5'd0:    rom_lookup = {1'b1, 1'b0, 16'h0001};  // soft reset
            5'd1:    rom_lookup = {1'b1, 1'b0, 16'h0011};  // sleep out
            5'd2:    rom_lookup = {1'b0, 1'b0, 16'h003a};
            5'd3:    rom_lookup = {1'b0, 1'b1, 16'h0055};  // 16 bpp
            5'd4:    rom_lookup = {1'b0, 1'b0, 16'h0036};
            5'd5:    rom_lookup = {1'b0, 1'b1, 16'h0008};
            5'd6:    rom_lookup = {1'b0, 1'b0, 16'h002a};
            5'd7:    rom_lookup = {1'b0, 1'b1, 16'h0000};
            5'd8:    rom_lookup = {1'b0, 1'b1, 16'h000f};
            5'd9:    rom_lookup = {1'b0, 1'b0, 16'h0029};  // display on
            default: rom_lookup = {1'b0, 1'b1, logo_val};
        endcase
    endfunction

    always_ff @(posedge pclk) begin
        rom_word <= rom_lookup(rom_addr);
    end

    a_addr_range: assert property (@(posedge pclk) rom_addr < rom_addr_w'(rom_depth))
        else $error("rom address %0d out of range", rom_addr);

endmodule

`default_nettype wire

/* logic/lcd_init.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_init import lcd_pkg::*; (
    input  logic                  pclk,
    input  logic                  rst_n,
    input  logic                  init_restart,
    input  logic                  write_ok,
    input  logic [rom_word_w-1:0] rom_word,
    output logic [rom_addr_w-1:0] rom_addr,
    output logic                  init_req,
    output logic                  init_rs,
    output logic [15:0]           init_data,
    output logic                  init_busy,
    output logic                  init_finish
);

    init_state_e      state;
    logic [pix_w-1:0] pix_cnt;
    logic [dly_w-1:0] dly_cnt;

    // rom_word follows rom_addr one edge later, same edge that raises init_req
    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            state    <= idle;
            rom_addr <= '0;
            init_req <= 1'b0;
            pix_cnt  <= '0;
            dly_cnt  <= '0;
        end else begin
            case (state)
                idle: begin
                    rom_addr <= '0;
                    init_req <= 1'b0;
                    pix_cnt  <= '0;
                    dly_cnt  <= '0;
                    state    <= script;
                end
                script, logo: begin
                    if (init_req) begin
                        if (write_ok) begin
                            init_req <= 1'b0;
                            if (state == logo) begin
                                if (rom_addr == rom_addr_w'(rom_depth - 1)) begin
                                    dly_cnt <= '0;
                                    state   <= keep;
                                end else begin
                                    rom_addr <= rom_addr + 1'b1;
                                end
                            end else begin
                                rom_addr <= rom_addr + 1'b1;
                                if (rom_word[wait_bit]) begin
                                    dly_cnt <= '0;
                                    state   <= script_wait;
                                end else if (rom_addr == rom_addr_w'(init_end)) begin
                                    state <= fill;
                                end
                            end
                        end
                    end else begin
                        init_req <= 1'b1;
                    end
                end
                script_wait: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (dly_cnt == dly_w'(delay_cycles - 1)) begin
                        // rom_addr already points past the waited word
                        if (rom_addr == rom_addr_w'(init_end + 1))
                            state <= fill;
                        else
                            state <= script;
                    end
                end
                fill: begin
                    if (init_req) begin
                        if (write_ok) begin
                            init_req <= 1'b0;
                            pix_cnt  <= pix_cnt + 1'b1;
                            if (pix_cnt == pix_w'(frame_pixels - 1))
                                state <= logo;
                        end
                    end else begin
                        init_req <= 1'b1;
                    end
                end
                keep: begin
                    dly_cnt <= dly_cnt + 1'b1;
                    if (dly_cnt == dly_w'(keep_cycles - 1))
                        state <= done;
                end
                done: begin
                    if (init_restart)
                        state <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    assign init_rs     = (state == fill) ? 1'b1 : rom_word[rs_bit];
    assign init_data   = (state == fill) ? fill_color : rom_word[15:0];
    assign init_busy   = (state != done);
    assign init_finish = (state == done);

    // bus is with the cpu by then, a request here would be lost
    a_no_req_done: assert property (@(posedge pclk) disable iff (!rst_n)
        (state == done) |-> !init_req && !write_ok)
        else $error("init request or completion while done");

endmodule

`default_nettype wire

/* logic/lcd_axil_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_axil_slave import lcd_pkg::*; (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic [axil_addr_w-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axil_data_w-1:0]   wdata,
    input  logic [axil_data_w/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [axil_addr_w-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axil_data_w-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    input  logic                     init_finish,
    input  logic                     cpu_ok,
    output logic                     cpu_req,
    output logic                     cpu_rs,
    output logic [15:0]              cpu_data,
    output logic                     init_restart
);

    axil_wstate_e wstate;
    logic         aw_hs;
    logic         ar_hs;
    logic         wr_panel;

    // aw and w are taken together
    assign aw_hs    = (wstate == w_idle) && awvalid && wvalid;
    assign awready  = aw_hs;
    assign wready   = aw_hs;
    assign wr_panel = (awaddr == reg_cmd) || (awaddr == reg_data);

    assign arready = !rvalid;
    assign ar_hs   = arvalid && arready;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            wstate       <= w_idle;
            cpu_req      <= 1'b0;
            bvalid       <= 1'b0;
            bresp        <= resp_okay;
            init_restart <= 1'b0;
        end else begin
            init_restart <= 1'b0;
            case (wstate)
                w_idle: begin
                    if (aw_hs) begin
                        wstate <= w_issue;
                        bresp  <= resp_okay;
                        if (wr_panel && init_finish)
                            cpu_req <= 1'b1;
                        else if (wr_panel)
                            bresp <= resp_slverr;  // panel still owned by init
                        else if (awaddr == reg_ctrl)
                            init_restart <= wstrb[0] && wdata[0];
                        else
                            bresp <= resp_slverr;
                    end
                end
                w_issue: begin
                    // no request means the response is ready at once
                    if (!cpu_req || cpu_ok) begin
                        cpu_req <= 1'b0;
                        bvalid  <= 1'b1;
                        wstate  <= w_resp;
                    end
                end
                w_resp: begin
                    if (bready) begin
                        bvalid <= 1'b0;
                        wstate <= w_idle;
                    end
                end
                default: begin
                    wstate <= w_idle;
                end
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (aw_hs) begin
            cpu_rs   <= (awaddr == reg_data);
            cpu_data <= wdata[15:0];
        end
    end

    always_ff @(posedge pclk) begin
        if (!rst_n)
            rvalid <= 1'b0;
        else if (ar_hs)
            rvalid <= 1'b1;
        else if (rready)
            rvalid <= 1'b0;
    end

    always_ff @(posedge pclk) begin
        if (ar_hs) begin
            if (araddr == reg_status) begin
                rdata <= {{(axil_data_w - 2){1'b0}}, cpu_req, init_finish};
                rresp <= resp_okay;
            end else begin
                rdata <= '0;
                rresp <= resp_slverr;
            end
        end
    end

    a_bvalid_hold: assert property (@(posedge pclk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
        else $error("bvalid dropped before bready");

endmodule

`default_nettype wire

/* logic/lcd_bus_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_bus_writer import lcd_pkg::*; (
    input  logic        pclk,
    input  logic        rst_n,
    input  logic        init_busy,
    input  logic        init_req,
    input  logic        init_rs,
    input  logic [15:0] init_data,
    input  logic        cpu_req,
    input  logic        cpu_rs,
    input  logic [15:0] cpu_data,
    output logic        write_ok,
    output logic        cpu_ok,
    output logic        cs_n,
    output logic        wr_n,
    output logic        rs,
    output logic [15:0] db
);

    logic               active;
    logic               src_cpu;
    logic [phase_w-1:0] phase;
    logic               pick_req;
    logic               accept;
    logic               last;

    // init owns the bus until it is done
    assign pick_req = init_busy ? init_req : cpu_req;
    assign accept   = !active && pick_req;
    assign last     = active && (phase == phase_w'(wr_low_cycles + wr_high_cycles - 1));
    assign write_ok = last && !src_cpu;
    assign cpu_ok   = last && src_cpu;

    always_ff @(posedge pclk) begin
        if (!rst_n) begin
            active  <= 1'b0;
            src_cpu <= 1'b0;
            phase   <= '0;
            cs_n    <= 1'b1;
            wr_n    <= 1'b1;
        end else if (accept) begin
            active  <= 1'b1;
            src_cpu <= !init_busy;
            phase   <= '0;
            cs_n    <= 1'b0;
            wr_n    <= 1'b0;
        end else if (active) begin
            phase <= phase + 1'b1;
            if (phase == phase_w'(wr_low_cycles - 1))
                wr_n <= 1'b1;  // panel latches here
            if (last) begin
                active <= 1'b0;
                cs_n   <= 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (accept) begin
            rs <= init_busy ? init_rs : cpu_rs;
            db <= init_busy ? init_data : cpu_data;
        end
    end

    a_db_stable: assert property (@(posedge pclk) disable iff (!rst_n)
        !cs_n |=> cs_n || ($stable(db) && $stable(rs)))
        else $error("db or rs changed inside a write");

endmodule

`default_nettype wire

/* logic/lcd_top.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_top import lcd_pkg::*; (
    input  logic                     pclk,
    input  logic                     rst_n,
    input  logic [axil_addr_w-1:0]   awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  logic [axil_data_w-1:0]   wdata,
    input  logic [axil_data_w/8-1:0] wstrb,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    input  logic [axil_addr_w-1:0]   araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output logic [axil_data_w-1:0]   rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready,
    output logic                     cs_n,
    output logic                     wr_n,
    output logic                     rs,
    output logic [15:0]              db
);

    logic [rom_addr_w-1:0] rom_addr;
    logic [rom_word_w-1:0] rom_word;
    logic                  init_req;
    logic                  init_rs;
    logic [15:0]           init_data;
    logic                  init_busy;
    logic                  init_finish;
    logic                  init_restart;
    logic                  write_ok;
    logic                  cpu_req;
    logic                  cpu_rs;
    logic [15:0]           cpu_data;
    logic                  cpu_ok;

    lcd_axil_slave u_slave (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .awaddr       (awaddr),
        .awvalid      (awvalid),
        .awready      (awready),
        .wdata        (wdata),
        .wstrb        (wstrb),
        .wvalid       (wvalid),
        .wready       (wready),
        .bresp        (bresp),
        .bvalid       (bvalid),
        .bready       (bready),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .rready       (rready),
        .init_finish  (init_finish),
        .cpu_ok       (cpu_ok),
        .cpu_req      (cpu_req),
        .cpu_rs       (cpu_rs),
        .cpu_data     (cpu_data),
        .init_restart (init_restart)
    );

    lcd_init u_init (
        .pclk         (pclk),
        .rst_n        (rst_n),
        .init_restart (init_restart),
        .write_ok     (write_ok),
        .rom_word     (rom_word),
        .rom_addr     (rom_addr),
        .init_req     (init_req),
        .init_rs      (init_rs),
        .init_data    (init_data),
        .init_busy    (init_busy),
        .init_finish  (init_finish)
    );

    lcd_init_rom u_rom (
        .pclk     (pclk),
        .rom_addr (rom_addr),
        .rom_word (rom_word)
    );

    lcd_bus_writer u_writer (
        .pclk      (pclk),
        .rst_n     (rst_n),
        .init_busy (init_busy),
        .init_req  (init_req),
        .init_rs   (init_rs),
        .init_data (init_data),
        .cpu_req   (cpu_req),
        .cpu_rs    (cpu_rs),
        .cpu_data  (cpu_data),
        .write_ok  (write_ok),
        .cpu_ok    (cpu_ok),
        .cs_n      (cs_n),
        .wr_n      (wr_n),
        .rs        (rs),
        .db        (db)
    );

endmodule

`default_nettype wire

/* tests/lcd_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module lcd_tb import lcd_pkg::*; ();

    logic                     pclk;
    logic                     rst_n;
    logic [axil_addr_w-1:0]   awaddr;
    logic                     awvalid;
    logic                     awready;
    logic [axil_data_w-1:0]   wdata;
    logic [axil_data_w/8-1:0] wstrb;
    logic                     wvalid;
    logic                     wready;
    logic [1:0]               bresp;
    logic                     bvalid;
    logic                     bready;
    logic [axil_addr_w-1:0]   araddr;
    logic                     arvalid;
    logic                     arready;
    logic [axil_data_w-1:0]   rdata;
    logic [1:0]               rresp;
    logic                     rvalid;
    logic                     rready;
    logic                     cs_n;
    logic                     wr_n;
    logic                     rs;
    logic [15:0]              db;

    string       trace_q[$];
    logic [16:0] panel_q[$];   // {rs, db} per wr_n rising edge
    string       cur_test;
    int          panel_idx;
    int          errors;
    int          checks;
    int          limit;
    int          cycles;
    int          low_cnt;
    logic        prev_wr_n;

    lcd_top u_dut (
        .pclk    (pclk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .cs_n    (cs_n),
        .wr_n    (wr_n),
        .rs      (rs),
        .db      (db)
    );

    initial begin
        pclk = 1'b0;
        forever #10 pclk = ~pclk;
    end

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        checks++;
        assert (exp === got) else begin
            errors++;
            $display("[ERROR] %s expected %h actual %h", name, exp, got);
        end
    endtask

    task automatic show_counts();
        $display("checks: %0d  errors: %0d", checks, errors);
    endtask

    // panel monitor, sampled mid-cycle
    always @(negedge pclk) begin
        if (rst_n) begin
            if (!wr_n) begin
                low_cnt++;
                check_value({cur_test, " cs_n under wr_n"}, 32'd0, 32'(cs_n));
            end else if (!prev_wr_n) begin
                check_value({cur_test, " wr_n low width"}, 32'(wr_low_cycles), 32'(low_cnt));
                check_value({cur_test, " cs_n at wr_n rise"}, 32'd0, 32'(cs_n));
                panel_q.push_back({rs, db});
                low_cnt = 0;
            end
        end
        prev_wr_n = wr_n;
    end

    task automatic axi_write(input logic [axil_addr_w-1:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int unsigned delay;
        @(negedge pclk);
        awaddr  = addr;
        wdata   = data;
        wstrb   = 4'hf;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        do @(posedge pclk); while (!(awready && wready));
        @(negedge pclk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        do @(posedge pclk); while (!bvalid);
        resp  = bresp;
        delay = $urandom_range(3, 0);  // bready back-pressure
        repeat (delay) @(posedge pclk);
        @(negedge pclk);
        bready = 1'b1;
        @(posedge pclk);
        @(negedge pclk);
        bready = 1'b0;
    endtask

    task automatic axi_read(input logic [axil_addr_w-1:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge pclk);
        araddr  = addr;
        arvalid = 1'b1;
        do @(posedge pclk); while (!arready);
        @(negedge pclk);
        arvalid = 1'b0;
        rready  = 1'b1;
        do @(posedge pclk); while (!rvalid);
        data = rdata;
        resp = rresp;
        @(negedge pclk);
        rready = 1'b0;
    endtask

    // poll status until init_finish
    task automatic wait_init();
        logic [31:0] d;
        logic [1:0]  r;
        d = '0;
        while (!d[0])
            axi_read(reg_status, d, r);
    endtask

    task automatic expect_panel(input logic rs_exp, input logic [15:0] data_exp);
        logic [16:0] got;
        while (panel_q.size() == 0)
            @(posedge pclk);
        got = panel_q.pop_front();
        panel_idx++;
        check_value($sformatf("%s panel write %0d", cur_test, panel_idx),
                    {15'd0, rs_exp, data_exp}, {15'd0, got});
    endtask

    task automatic run_line(input string line);
        string       kind;
        string       name;
        int          count;
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [15:0] pix;
        logic [31:0] got_data;
        logic [1:0]  got_resp;
        void'($sscanf(line, "%s", kind));
        case (kind)
            "T": begin
                void'($sscanf(line, "%s %s", kind, name));
                cur_test  = name;
                panel_idx = 0;
            end
            "I": wait_init();
            "W": begin
                void'($sscanf(line, "%s %h %h %h", kind, a, b, c));
                axi_write(a[axil_addr_w-1:0], b, got_resp);
                check_value({cur_test, " bresp"}, c, 32'(got_resp));
            end
            "R": begin
                void'($sscanf(line, "%s %h %h %h", kind, a, b, c));
                axi_read(a[axil_addr_w-1:0], got_data, got_resp);
                check_value({cur_test, " rdata"}, b, got_data);
                check_value({cur_test, " rresp"}, c, 32'(got_resp));
            end
            "P": begin
                void'($sscanf(line, "%s %h %h", kind, a, b));
                expect_panel(a[0], b[15:0]);
            end
            "F": begin
                void'($sscanf(line, "%s %d %h %h %h", kind, count, a, b, c));
                pix = b[15:0];
                for (i = 0; i < count; i++) begin
                    expect_panel(a[0], pix);
                    pix = pix + c[15:0];  // wraps at 16 bits
                end
            end
            "E": check_value({cur_test, " extra panel writes"}, 32'd0, 32'(panel_q.size()));
            default: begin
                errors++;
                $display("unknown trace line: %s", line);
            end
        endcase
    endtask

    initial begin
        cycles = 0;
        wait (limit > 0);
        while (cycles < limit) begin
            @(posedge pclk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", limit);
        show_counts();
        $display("sim failed");
        $finish;
    end

    initial begin
        int    fd;
        string line;
        rst_n     = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        cur_test  = "reset";
        panel_idx = 0;
        errors    = 0;
        checks    = 0;
        low_cnt   = 0;
        prev_wr_n = 1'b1;
        void'($urandom(32'hc915));

        fd = $fopen("tests/lcd_trace.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("cannot open trace file tests/lcd_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#")
                    trace_q.push_back(line);
            end
            $fclose(fd);
        end
        limit = 2000 + 8 * trace_q.size();

        repeat (5) @(posedge pclk);
        @(negedge pclk);
        rst_n = 1'b1;

        foreach (trace_q[i])
            run_line(trace_q[i]);

        show_counts();
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* tests/lcd_trace.txt */
# T name | I wait for init | W addr wdata bresp | R addr rdata rresp | P rs data
# F count(decimal) rs data step | E no panel write left | other numbers hex
T early_write
W 8 00001234 2
T init_seq
P 0 0001
P 0 0011
P 0 003a
P 1 0055
P 0 0036
P 1 0008
P 0 002a
P 1 0000
P 1 000f
P 0 0029
F 16 1 ffff 0000
F 14 1 f800 0101
I
R 0 00000001 0
E
T cpu_write
W 4 1234abcd 0
P 0 abcd
W 8 00c0ffee 0
P 1 ffee
W 8 0000f00d 0
P 1 f00d
R 0 00000001 0
T bad_addr
W 6 5a5a5a5a 2
R 6 00000000 2
R 4 00000000 2
E
T restart
W c 00000001 0
R 0 00000000 0
P 0 0001
P 0 0011
P 0 003a
P 1 0055
P 0 0036
P 1 0008
P 0 002a
P 1 0000
P 1 000f
P 0 0029
F 16 1 ffff 0000
F 14 1 f800 0101
I
R 0 00000001 0
E

/* list.f */
logic/lcd_pkg.sv
logic/lcd_init_rom.sv
logic/lcd_init.sv
logic/lcd_axil_slave.sv
logic/lcd_bus_writer.sv
logic/lcd_top.sv
tests/lcd_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = lcd_tb
FILELIST  = list.f
OBJDIR    = obj_dir
BIN       = V$(TOP)
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -o $(BIN) -f $(FILELIST)
	./$(OBJDIR)/$(BIN) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
